/* design/l2_consts.svh */
`ifndef L2_CONSTS_SVH
`define L2_CONSTS_SVH

// cache geometry
`define L2_TAG_W     22
`define L2_INDEX_W   4
`define L2_WAY_W     2
`define L2_WAYS      4
`define L2_SETS      16

// 2-bit age per way
`define L2_AGE_W     2

// way n starts with age n
`define L2_AGE_RESET 8'b11_10_01_00

`endif

/* design/l2_pkg.sv */
`default_nettype none

`include "l2_consts.svh"

package l2_pkg;

    typedef logic [`L2_TAG_W-1:0] tag_t;
    typedef logic [`L2_INDEX_W-1:0] index_t;
    typedef logic [`L2_WAY_W-1:0] way_t;

    // one bit per way of a set
    typedef logic [`L2_WAYS-1:0] way_mask_t;

    // way n ages in slice n
    typedef logic [`L2_WAYS*`L2_AGE_W-1:0] set_ages_t;

    typedef enum logic [1:0]
    {
        IDLE,
        COMPARE,
        WRITE_BACK,
        ALLOCATE
    } ctrl_state_t;

endpackage

`default_nettype wire

/* design/l2_req_latch.sv */
`default_nettype none

module l2_req_latch (
    input  wire logic           clk,
    input  wire logic           nrst,
    input  wire logic           req_valid,
    input  wire logic           req_write,
    input  wire l2_pkg::tag_t   req_tag,
    input  wire l2_pkg::index_t req_index,
    input  wire logic           flush,
    input  wire logic           resp_done,
    output logic                pending,
    output logic                cur_write,
    output l2_pkg::tag_t        cur_tag,
    output l2_pkg::index_t      cur_index,
    output logic                flush_go,
    output logic                busy
);

    logic req_seen;

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            req_seen <= 1'b0;
            pending  <= 1'b0;
            flush_go <= 1'b0;
            busy     <= 1'b0;
        end
        else
        begin
            // held address settles one cycle before the lookup starts
            req_seen <= req_valid;
            pending  <= req_seen;
            flush_go <= flush;
            if (req_valid || flush)
                busy <= 1'b1;
            else if (resp_done || flush_go)
                busy <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (req_valid)
        begin
            cur_write <= req_write;
            cur_tag   <= req_tag;
            cur_index <= req_index;
        end
    end

    // caller must hold off until the previous transaction is answered
    a_strobe_legal : assert property (@(posedge clk) disable iff (!nrst)
        (req_valid || flush) |-> (!busy && !(req_valid && flush)));

endmodule

`default_nettype wire

/* design/l2_tag_store.sv */
`default_nettype none

`include "l2_consts.svh"

module l2_tag_store (
    input  wire logic           clk,
    input  wire logic           nrst,
    input  wire l2_pkg::tag_t   cur_tag,
    input  wire l2_pkg::index_t cur_index,
    input  wire logic           set_dirty,
    input  wire logic           fill,
    input  wire l2_pkg::way_t   fill_way,
    input  wire logic           flush_go,
    input  wire l2_pkg::way_t   victim,
    output logic                hit,
    output l2_pkg::way_t        hit_way,
    output l2_pkg::way_mask_t   set_valid,
    output logic                victim_dirty,
    output l2_pkg::tag_t        victim_tag
);

    import l2_pkg::*;

    localparam int LINES = `L2_SETS * `L2_WAYS;

    tag_t                                 tags [LINES];
    logic [LINES-1:0]                     valid;
    logic [LINES-1:0]                     dirty;
    way_mask_t                            match;
    logic [`L2_INDEX_W+`L2_WAY_W-1:0]     victim_line;
    logic [`L2_INDEX_W+`L2_WAY_W-1:0]     fill_line;
    logic [`L2_INDEX_W+`L2_WAY_W-1:0]     hit_line;

    assign victim_line = {cur_index, victim};
    assign fill_line   = {cur_index, fill_way};
    assign hit_line    = {cur_index, hit_way};

    // four-way compare on the held set
    always_comb
    begin
        hit_way = '0;
        for (int w = 0; w < `L2_WAYS; w++)
        begin
            set_valid[w] = valid[{cur_index, way_t'(w)}];
            match[w] = set_valid[w] && (tags[{cur_index, way_t'(w)}] == cur_tag);
            if (match[w])
                hit_way = way_t'(w);
        end
    end

    assign hit = |match;

    // a clean or invalid victim needs no write-back
    assign victim_dirty = valid[victim_line] && dirty[victim_line];
    assign victim_tag   = tags[victim_line];

    always_ff @(posedge clk)
    begin
        if (fill)
            tags[fill_line] <= cur_tag;
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            valid <= '0;
            dirty <= '0;
        end
        else if (flush_go)
        begin
            valid <= '0;
            dirty <= '0;
        end
        else
        begin
            if (fill)
            begin
                valid[fill_line] <= 1'b1;
                dirty[fill_line] <= 1'b0;
            end
            if (set_dirty)
                dirty[hit_line] <= 1'b1;
        end
    end

    // fills only go to missed sets, so a tag never sits in two ways
    a_one_match : assert property (@(posedge clk) disable iff (!nrst)
        $onehot0(match));

endmodule

`default_nettype wire

/* design/l2_lru.sv */
`default_nettype none

`include "l2_consts.svh"

module l2_lru (
    input  wire logic              clk,
    input  wire logic              nrst,
    input  wire l2_pkg::index_t    cur_index,
    input  wire l2_pkg::way_mask_t set_valid,
    input  wire logic              touch,
    input  wire l2_pkg::way_t      touch_way,
    output l2_pkg::way_t           victim
);

    import l2_pkg::*;

    set_ages_t              ages [`L2_SETS];
    set_ages_t              cur_ages;
    set_ages_t              next_ages;
    logic [`L2_AGE_W-1:0]   touch_age;
    logic                   found_invalid;

    assign cur_ages  = ages[cur_index];
    assign touch_age = cur_ages[touch_way*`L2_AGE_W +: `L2_AGE_W];

    // touched way becomes youngest, younger ones age by one
    always_comb
    begin
        logic [`L2_AGE_W-1:0] age_w;
        for (int w = 0; w < `L2_WAYS; w++)
        begin
            age_w = cur_ages[w*`L2_AGE_W +: `L2_AGE_W];
            if (way_t'(w) == touch_way)
                next_ages[w*`L2_AGE_W +: `L2_AGE_W] = '0;
            else if (age_w < touch_age)
                next_ages[w*`L2_AGE_W +: `L2_AGE_W] = age_w + 1'b1;
            else
                next_ages[w*`L2_AGE_W +: `L2_AGE_W] = age_w;
        end
    end

    // lowest invalid way first, else the oldest
    always_comb
    begin
        victim = '0;
        found_invalid = 1'b0;
        for (int w = 0; w < `L2_WAYS; w++)
        begin
            if (!found_invalid && !set_valid[w])
            begin
                victim = way_t'(w);
                found_invalid = 1'b1;
            end
        end
        if (!found_invalid)
        begin
            for (int w = 0; w < `L2_WAYS; w++)
            begin
                if (cur_ages[w*`L2_AGE_W +: `L2_AGE_W] == '1)
                    victim = way_t'(w);
            end
        end
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            for (int s = 0; s < `L2_SETS; s++)
                ages[s] <= `L2_AGE_RESET;
        end
        else if (touch)
            ages[cur_index] <= next_ages;
    end

endmodule

`default_nettype wire

/* design/l2_ctrl_fsm.sv */
`default_nettype none

module l2_ctrl_fsm (
    input  wire logic         clk,
    input  wire logic         nrst,
    input  wire logic         pending,
    input  wire logic         cur_write,
    input  wire logic         hit,
    input  wire l2_pkg::way_t hit_way,
    input  wire l2_pkg::way_t victim,
    input  wire logic         victim_dirty,
    input  wire logic         mem_done,
    output logic              resp_valid,
    output logic              resp_hit,
    output logic              data_update,
    output logic              refill,
    output l2_pkg::way_t      way,
    output logic              set_dirty,
    output logic              fill,
    output l2_pkg::way_t      fill_way,
    output logic              touch,
    output logic              start_evict,
    output logic              start_fill
);

    import l2_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;
    way_t        victim_q;
    logic        missed;

    assign fill_way = victim_q;

    always_comb
    begin
        next_state  = state;
        set_dirty   = 1'b0;
        fill        = 1'b0;
        touch       = 1'b0;
        start_evict = 1'b0;
        start_fill  = 1'b0;
        case (state)
            IDLE:
                if (pending)
                    next_state = COMPARE;
            COMPARE:
                if (hit)
                begin
                    touch      = 1'b1;
                    set_dirty  = cur_write;
                    next_state = IDLE;
                end
                else if (victim_dirty)
                begin
                    start_evict = 1'b1;
                    next_state  = WRITE_BACK;
                end
                else
                begin
                    start_fill = 1'b1;
                    next_state = ALLOCATE;
                end
            WRITE_BACK:
                if (mem_done)
                begin
                    start_fill = 1'b1;
                    next_state = ALLOCATE;
                end
            ALLOCATE:
                // after the fill the lookup runs again and hits
                if (mem_done)
                begin
                    fill       = 1'b1;
                    next_state = COMPARE;
                end
            default:
                next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            state       <= IDLE;
            resp_valid  <= 1'b0;
            resp_hit    <= 1'b0;
            data_update <= 1'b0;
            refill      <= 1'b0;
            missed      <= 1'b0;
        end
        else
        begin
            state       <= next_state;
            resp_valid  <= (state == COMPARE) && hit;
            data_update <= (state == COMPARE) && hit && cur_write;
            refill      <= (state == ALLOCATE) && mem_done;
            if (state == COMPARE)
            begin
                if (hit)
                begin
                    resp_hit <= !missed;
                    missed   <= 1'b0;
                end
                else
                    missed <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if ((state == COMPARE) && !hit)
            victim_q <= victim;
        if ((state == COMPARE) && hit)
            way <= hit_way;
        else if ((state == ALLOCATE) && mem_done)
            way <= victim_q;
    end

endmodule

`default_nettype wire

/* design/l2_mem_port.sv */
`default_nettype none

module l2_mem_port (
    input  wire logic           clk,
    input  wire logic           nrst,
    input  wire logic           start_evict,
    input  wire logic           start_fill,
    input  wire l2_pkg::tag_t   cur_tag,
    input  wire l2_pkg::tag_t   victim_tag,
    input  wire l2_pkg::index_t cur_index,
    input  wire logic           mem_ready,
    output logic                mem_rd,
    output logic                mem_wr,
    output l2_pkg::tag_t        mem_tag,
    output l2_pkg::index_t      mem_index,
    output logic                mem_done
);

    // request levels drop the cycle after mem_ready
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            mem_rd <= 1'b0;
            mem_wr <= 1'b0;
        end
        else
        begin
            if (start_fill)
                mem_rd <= 1'b1;
            else if (mem_ready)
                mem_rd <= 1'b0;
            if (start_evict)
                mem_wr <= 1'b1;
            else if (mem_ready)
                mem_wr <= 1'b0;
        end
    end

    // write-back carries the victim tag, refill the request tag
    always_ff @(posedge clk)
    begin
        if (start_evict)
            mem_tag <= victim_tag;
        else if (start_fill)
            mem_tag <= cur_tag;
        if (start_evict || start_fill)
            mem_index <= cur_index;
    end

    assign mem_done = (mem_rd || mem_wr) && mem_ready;

    a_one_request : assert property (@(posedge clk) disable iff (!nrst)
        !(mem_rd && mem_wr));

endmodule

`default_nettype wire

/* design/l2_ctrl_top.sv */
`default_nettype none

module l2_ctrl_top (
    input  wire logic           clk,
    input  wire logic           nrst,
    input  wire logic           req_valid,
    input  wire logic           req_write,
    input  wire l2_pkg::tag_t   req_tag,
    input  wire l2_pkg::index_t req_index,
    input  wire logic           flush,
    output logic                busy,
    output logic                resp_valid,
    output logic                resp_hit,
    output logic                data_update,
    output logic                refill,
    output l2_pkg::way_t        way,
    output logic                mem_rd,
    output logic                mem_wr,
    output l2_pkg::tag_t        mem_tag,
    output l2_pkg::index_t      mem_index,
    input  wire logic           mem_ready
);

    import l2_pkg::*;

    logic      pending;
    logic      cur_write;
    tag_t      cur_tag;
    index_t    cur_index;
    logic      flush_go;
    logic      hit;
    way_t      hit_way;
    way_mask_t set_valid;
    logic      victim_dirty;
    tag_t      victim_tag;
    way_t      victim;
    logic      set_dirty;
    logic      fill;
    way_t      fill_way;
    logic      touch;
    logic      start_evict;
    logic      start_fill;
    logic      mem_done;

    l2_req_latch i_req_latch (
        .clk, .nrst, .req_valid, .req_write, .req_tag, .req_index, .flush,
        .resp_done (resp_valid),
        .pending, .cur_write, .cur_tag, .cur_index, .flush_go, .busy
    );

    l2_ctrl_fsm i_ctrl_fsm (
        .clk, .nrst, .pending, .cur_write, .hit, .hit_way, .victim, .victim_dirty,
        .mem_done, .resp_valid, .resp_hit, .data_update, .refill, .way,
        .set_dirty, .fill, .fill_way, .touch, .start_evict, .start_fill
    );

    l2_tag_store i_tag_store (
        .clk, .nrst, .cur_tag, .cur_index, .set_dirty, .fill, .fill_way, .flush_go,
        .victim, .hit, .hit_way, .set_valid, .victim_dirty, .victim_tag
    );

    // the LRU is touched on the way that hit
    l2_lru i_lru (
        .clk, .nrst, .cur_index, .set_valid, .touch,
        .touch_way (hit_way),
        .victim
    );

    l2_mem_port i_mem_port (
        .clk, .nrst, .start_evict, .start_fill, .cur_tag, .victim_tag, .cur_index,
        .mem_ready, .mem_rd, .mem_wr, .mem_tag, .mem_index, .mem_done
    );

endmodule

`default_nettype wire

/* verif/l2_ref_model.svh */
`ifndef L2_REF_MODEL_SVH
`define L2_REF_MODEL_SVH

// model of the tag side of the cache
tag_t                 m_tag   [`L2_SETS][`L2_WAYS];
logic                 m_valid [`L2_SETS][`L2_WAYS];
logic                 m_dirty [`L2_SETS][`L2_WAYS];
logic [`L2_AGE_W-1:0] m_age   [`L2_SETS][`L2_WAYS];

// flush keeps the ages, reset starts way n at age n
function automatic void model_clear(input logic keep_ages);
    for (int s = 0; s < `L2_SETS; s++)
    begin
        for (int w = 0; w < `L2_WAYS; w++)
        begin
            m_valid[s][w] = 1'b0;
            m_dirty[s][w] = 1'b0;
            if (!keep_ages)
                m_age[s][w] = w[`L2_AGE_W-1:0];
        end
    end
endfunction

function automatic logic model_lookup(input index_t idx, input tag_t tag, output way_t hway);
    logic found;
    found = 1'b0;
    hway = '0;
    for (int w = 0; w < `L2_WAYS; w++)
    begin
        if (m_valid[idx][w] && (m_tag[idx][w] == tag))
        begin
            found = 1'b1;
            hway = way_t'(w);
        end
    end
    return found;
endfunction

// lowest invalid way, else the oldest one
function automatic way_t model_victim(input index_t idx);
    for (int w = 0; w < `L2_WAYS; w++)
    begin
        if (!m_valid[idx][w])
            return way_t'(w);
    end
    for (int w = 0; w < `L2_WAYS; w++)
    begin
        if (m_age[idx][w] == '1)
            return way_t'(w);
    end
    return '0;
endfunction

function automatic void model_touch(input index_t idx, input way_t hway);
    logic [`L2_AGE_W-1:0] a;
    a = m_age[idx][hway];
    for (int w = 0; w < `L2_WAYS; w++)
    begin
        if ((way_t'(w) != hway) && (m_age[idx][w] < a))
            m_age[idx][w] = m_age[idx][w] + 1'b1;
    end
    m_age[idx][hway] = '0;
endfunction

function automatic void model_fill(input index_t idx, input way_t w, input tag_t tag);
    m_tag[idx][w]   = tag;
    m_valid[idx][w] = 1'b1;
    m_dirty[idx][w] = 1'b0;
endfunction

`endif

/* verif/tb_l2_ctrl.sv */
`default_nettype none

`include "l2_consts.svh"

module tb_l2_ctrl;

    import l2_pkg::*;

    localparam int NUM_OPS       = 1500;
    localparam int OP_TIMEOUT    = 100;
    localparam int MEM_DELAY_MAX = 5;
    localparam int TAG_POOL      = 6;

    logic   clk;
    logic   nrst;
    logic   req_valid;
    logic   req_write;
    tag_t   req_tag;
    index_t req_index;
    logic   flush;
    logic   busy;
    logic   resp_valid;
    logic   resp_hit;
    logic   data_update;
    logic   refill;
    way_t   way;
    logic   mem_rd;
    logic   mem_wr;
    tag_t   mem_tag;
    index_t mem_index;
    logic   mem_ready;

    integer seed;
    int     hit_count;
    int     writeback_count;
    int     flush_count;
    int     fresh_miss_count;
    logic   fresh_set [`L2_SETS];

    `include "l2_ref_model.svh"

    l2_ctrl_top i_dut (
        .clk, .nrst, .req_valid, .req_write, .req_tag, .req_index, .flush,
        .busy, .resp_valid, .resp_hit, .data_update, .refill, .way,
        .mem_rd, .mem_wr, .mem_tag, .mem_index, .mem_ready
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("ERROR %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    task automatic check_way(input string name, input way_t got, input way_t exp);
        if (got !== exp)
            abort_run($sformatf("ERROR %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    task automatic check_tag(input string name, input tag_t got, input tag_t exp);
        if (got !== exp)
            abort_run($sformatf("ERROR %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    task automatic check_index(input string name, input index_t got, input index_t exp);
        if (got !== exp)
            abort_run($sformatf("ERROR %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    task automatic next_cycle();
        @(negedge clk);
    endtask

    // a few tags per set, so lines get both reused and evicted
    function automatic tag_t pool_tag(input index_t idx, input int slot);
        return tag_t'((slot + 1) * 32'h0001_3a5d + idx * 32'h100);
    endfunction

    task automatic run_access(input logic write, input index_t idx, input tag_t tag);
        logic exp_hit;
        logic exp_wb;
        way_t exp_way;
        tag_t wb_tag;
        logic seen_wr;
        logic seen_rd;
        logic seen_refill;
        logic done;
        logic first_after_flush;
        int   cycles;

        exp_hit = model_lookup(idx, tag, exp_way);
        exp_wb = 1'b0;
        wb_tag = '0;
        if (!exp_hit)
        begin
            exp_way = model_victim(idx);
            exp_wb = m_valid[idx][exp_way] && m_dirty[idx][exp_way];
            wb_tag = m_tag[idx][exp_way];
            model_fill(idx, exp_way, tag);
        end
        model_touch(idx, exp_way);
        if (write)
            m_dirty[idx][exp_way] = 1'b1;
        first_after_flush = fresh_set[idx];
        if (first_after_flush)
        begin
            fresh_set[idx] = 1'b0;
            fresh_miss_count++;
        end
        if (exp_hit)
            hit_count++;
        if (exp_wb)
            writeback_count++;

        req_valid = 1'b1;
        req_write = write;
        req_tag   = tag;
        req_index = idx;
        next_cycle();
        req_valid = 1'b0;
        seen_wr = 1'b0;
        seen_rd = 1'b0;
        seen_refill = 1'b0;
        done = 1'b0;
        cycles = 1;
        while (!done)
        begin
            if (cycles > OP_TIMEOUT)
                abort_run("no response to the request within the timeout");
            check_bit("busy", busy, 1'b1);
            if (mem_wr && !seen_wr)
            begin
                check_bit("mem_wr", mem_wr, exp_wb);
                check_tag("mem_tag", mem_tag, wb_tag);
                check_index("mem_index", mem_index, idx);
                seen_wr = 1'b1;
            end
            if (mem_rd && !seen_rd)
            begin
                check_bit("mem_rd", mem_rd, !exp_hit);
                // write-back must come first
                check_bit("mem_wr", seen_wr, exp_wb);
                check_tag("mem_tag", mem_tag, tag);
                check_index("mem_index", mem_index, idx);
                seen_rd = 1'b1;
            end
            if (refill)
            begin
                check_bit("refill", refill, !exp_hit && seen_rd && !seen_refill);
                check_way("way", way, exp_way);
                seen_refill = 1'b1;
            end
            if (resp_valid)
            begin
                check_bit("resp_hit", resp_hit, exp_hit);
                check_bit("refill", seen_refill, !exp_hit);
                if (exp_hit && (cycles != 4))
                    abort_run($sformatf("hit answered %0d cycles after the request, not 3",
                        cycles - 1));
                check_way("way", way, exp_way);
                check_bit("data_update", data_update, write);
                done = 1'b1;
            end
            else
                check_bit("data_update", data_update, 1'b0);
            next_cycle();
            cycles++;
        end
        check_bit("busy", busy, 1'b0);
        check_bit("resp_valid", resp_valid, 1'b0);
        // first touch of a set after a flush is a plain miss
        if (first_after_flush)
        begin
            check_bit("mem_wr", seen_wr, 1'b0);
            check_bit("refill", seen_refill, 1'b1);
        end
    endtask

    task automatic run_flush();
        model_clear(1'b1);
        for (int s = 0; s < `L2_SETS; s++)
            fresh_set[s] = 1'b1;
        flush = 1'b1;
        next_cycle();
        flush = 1'b0;
        check_bit("busy", busy, 1'b1);
        next_cycle();
        check_bit("busy", busy, 1'b0);
        flush_count++;
    endtask

    // memory answers each request level after a short random delay
    initial
    begin : mem_responder
        int delay;
        mem_ready = 1'b0;
        forever
        begin
            @(negedge clk);
            if (nrst && (mem_rd || mem_wr))
            begin
                delay = $unsigned($random(seed)) % (MEM_DELAY_MAX + 1);
                repeat (delay) @(negedge clk);
                mem_ready = 1'b1;
                @(negedge clk);
                mem_ready = 1'b0;
            end
        end
    end

    initial
    begin
        int     r;
        logic   write;
        index_t idx;
        tag_t   tag;

        seed = 32'haaf9;
        nrst = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_tag = '0;
        req_index = '0;
        flush = 1'b0;
        hit_count = 0;
        writeback_count = 0;
        flush_count = 0;
        fresh_miss_count = 0;
        model_clear(1'b0);
        for (int s = 0; s < `L2_SETS; s++)
            fresh_set[s] = 1'b0;

        repeat (2) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;
        check_bit("busy", busy, 1'b0);
        check_bit("resp_valid", resp_valid, 1'b0);
        check_bit("data_update", data_update, 1'b0);
        check_bit("refill", refill, 1'b0);

        for (int op = 0; op < NUM_OPS; op++)
        begin
            check_bit("mem_rd", mem_rd, 1'b0);
            check_bit("mem_wr", mem_wr, 1'b0);
            r = $unsigned($random(seed)) % 30;
            if (r == 0)
                run_flush();
            else
            begin
                idx = index_t'($unsigned($random(seed)) % `L2_SETS);
                tag = pool_tag(idx, $unsigned($random(seed)) % TAG_POOL);
                write = ($unsigned($random(seed)) % 3) == 0;
                run_access(write, idx, tag);
            end
        end

        if ((hit_count == 0) || (writeback_count == 0) || (flush_count == 0)
            || (fresh_miss_count == 0))
            abort_run("stimulus never reached a hit, a write-back or a flush");
        else
        begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+design
+incdir+verif
design/l2_pkg.sv
design/l2_req_latch.sv
design/l2_tag_store.sv
design/l2_lru.sv
design/l2_ctrl_fsm.sv
design/l2_mem_port.sv
design/l2_ctrl_top.sv
verif/tb_l2_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_l2_ctrl -o tb_l2_ctrl

sim_out=$(./obj_dir/tb_l2_ctrl 2>&1 || true)
echo "$sim_out"

if grep -q "All checks passed" <<< "$sim_out"; then
    exit 0
fi
exit 1
